//--- hw/lock_pkg.sv
package lock_pkg;

    localparam int CODE_DIGITS = 3;  // digits in one code

    // kind of a decoded key press
    typedef enum logic [1:0] {
        KEY_DIGIT     = 2'd0,
        KEY_ENTER     = 2'd1,
        KEY_CLR_ENTRY = 2'd2,
        KEY_CLR_ALL   = 2'd3
    } key_kind_e;

    typedef struct packed {
        logic      valid;  // high for one cycle per press
        key_kind_e kind;
        logic [3:0] digit;  // bcd, only meaningful for KEY_DIGIT
    } key_event_t;

    typedef enum logic [1:0] {
        MODE_ENTRY  = 2'd0,
        MODE_OPEN   = 2'd1,
        MODE_LOCKED = 2'd2
    } lock_mode_e;

    typedef struct packed {
        lock_mode_e       mode;
        logic [1:0]       count;   // digits entered so far
        logic [2:0][3:0]  digits;  // index 0 is rightmost
    } lock_view_t;

    // segments g..a, active high
    typedef logic [6:0] seg_t;

    typedef seg_t [2:0] seg_row_t;  // index 0 is rightmost

    localparam seg_t SEG_DIGIT [10] = '{
        7'h3f,  // 0
        7'h06,  // 1
        7'h5b,  // 2
        7'h4f,  // 3
        7'h66,  // 4
        7'h6d,  // 5
        7'h7d,  // 6
        7'h07,  // 7
        7'h7f,  // 8
        7'h6f   // 9
    };

    localparam seg_t SEG_BLANK = 7'h00;
    localparam seg_t SEG_P     = 7'h73;  // a b e f g
    localparam seg_t SEG_A     = 7'h77;
    localparam seg_t SEG_S     = 7'h6d;  // same shape as 5
    localparam seg_t SEG_DASH  = 7'h40;  // g only

endpackage

//--- hw/key_decoder.sv
`timescale 1ns/1ps

module key_decoder import lock_pkg::*; (
    input  logic        clk,
    input  logic        arst_n,
    input  logic [15:0] keys,
    output key_event_t  key_event
);

    logic [15:0] keys_q;     // current sample
    logic [15:0] keys_prev;  // sample one cycle earlier
    key_event_t  decoded;

    // one-hot level to event, unknown patterns give nothing
    always_comb begin
        decoded = '0;
        case (keys_q)
            16'h0001: decoded = '{valid: 1'b1, kind: KEY_ENTER,     digit: 4'd0};
            16'h0100: decoded = '{valid: 1'b1, kind: KEY_CLR_ALL,   digit: 4'd0};
            16'h1000: decoded = '{valid: 1'b1, kind: KEY_CLR_ENTRY, digit: 4'd0};
            16'h0008: decoded = '{valid: 1'b1, kind: KEY_DIGIT,     digit: 4'd0};
            16'h0080: decoded = '{valid: 1'b1, kind: KEY_DIGIT,     digit: 4'd1};
            16'h0040: decoded = '{valid: 1'b1, kind: KEY_DIGIT,     digit: 4'd2};
            16'h0020: decoded = '{valid: 1'b1, kind: KEY_DIGIT,     digit: 4'd3};
            16'h0800: decoded = '{valid: 1'b1, kind: KEY_DIGIT,     digit: 4'd4};
            16'h0400: decoded = '{valid: 1'b1, kind: KEY_DIGIT,     digit: 4'd5};
            16'h0200: decoded = '{valid: 1'b1, kind: KEY_DIGIT,     digit: 4'd6};
            16'h8000: decoded = '{valid: 1'b1, kind: KEY_DIGIT,     digit: 4'd7};
            16'h4000: decoded = '{valid: 1'b1, kind: KEY_DIGIT,     digit: 4'd8};
            16'h2000: decoded = '{valid: 1'b1, kind: KEY_DIGIT,     digit: 4'd9};
            default:  decoded = '0;  // none, several or unused keys
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            keys_q    <= '0;
            keys_prev <= '0;
            key_event <= '0;
        end else begin
            keys_q    <= keys;
            keys_prev <= keys_q;
            key_event <= decoded;
            // a held key only counts on its first sample
            if (keys_q == keys_prev) begin
                key_event.valid <= 1'b0;
            end
        end
    end

endmodule

//--- hw/code_lock.sv
`timescale 1ns/1ps

module code_lock import lock_pkg::*; #(
    parameter logic [11:0] PASSCODE      = 12'h246,
    parameter int          LOCKOUT_TRIES = 6,
    parameter int          TRIES_W       = 4
) (
    input  logic               clk,
    input  logic               arst_n,
    input  key_event_t         key_event,
    output lock_view_t         view,
    output logic [TRIES_W-1:0] tries,
    output logic               alarm
);

    localparam lock_view_t       VIEW_EMPTY = '{mode: MODE_ENTRY, count: 2'd0, digits: '0};
    localparam logic [TRIES_W-1:0] TRIES_MAX = TRIES_W'(LOCKOUT_TRIES);
    localparam logic [1:0]       FULL_COUNT = 2'(CODE_DIGITS);

    logic [TRIES_W-1:0] tries_inc;
    logic               code_match;
    logic               entry_full;

    assign tries_inc  = (tries == TRIES_MAX) ? tries : tries + 1'b1;  // saturates
    assign code_match = (view.digits == PASSCODE);  // digit 2 is most significant
    assign entry_full = (view.count == FULL_COUNT);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            view  <= VIEW_EMPTY;
            tries <= '0;
            alarm <= 1'b0;
        end else begin
            alarm <= 1'b0;  // one cycle only
            if (key_event.valid) begin
                if (key_event.kind == KEY_CLR_ALL) begin
                    view  <= VIEW_EMPTY;  // from any mode
                    tries <= '0;
                end else begin
                    case (view.mode)
                        MODE_ENTRY: begin
                            case (key_event.kind)
                                KEY_DIGIT: begin
                                    if (!entry_full) begin
                                        view.digits <= {view.digits[1:0], key_event.digit};
                                        view.count  <= view.count + 2'd1;
                                    end
                                end
                                KEY_ENTER: begin
                                    if (entry_full) begin
                                        if (code_match) begin
                                            view.mode <= MODE_OPEN;
                                        end else begin
                                            view       <= VIEW_EMPTY;
                                            tries      <= tries_inc;
                                            alarm      <= 1'b1;
                                            // last allowed try locks the pad
                                            if (tries_inc == TRIES_MAX) begin
                                                view.mode <= MODE_LOCKED;
                                            end
                                        end
                                    end
                                end
                                KEY_CLR_ENTRY: begin
                                    view <= VIEW_EMPTY;
                                end
                                default: begin
                                    view <= view;
                                end
                            endcase
                        end
                        MODE_OPEN: begin
                            if (key_event.kind == KEY_CLR_ENTRY) begin
                                view <= VIEW_EMPTY;  // relock
                            end
                        end
                        default: begin
                            view <= view;  // locked waits for clear all
                        end
                    endcase
                end
            end
        end
    end

endmodule

//--- hw/seg_display.sv
`timescale 1ns/1ps

module seg_display import lock_pkg::*; (
    input  logic       clk,
    input  logic       arst_n,
    input  lock_view_t view,
    output seg_row_t   seg
);

    seg_row_t seg_next;

    // guards against non-bcd values
    function automatic seg_t digit_seg(input logic [3:0] d);
        if (d <= 4'd9) begin
            return SEG_DIGIT[d];
        end
        return SEG_BLANK;
    endfunction

    always_comb begin
        seg_next = {3{SEG_BLANK}};
        case (view.mode)
            MODE_ENTRY: begin
                // right aligned, unused positions stay dark
                for (int i = 0; i < CODE_DIGITS; i++) begin
                    if (i < view.count) begin
                        seg_next[i] = digit_seg(view.digits[i]);
                    end
                end
            end
            MODE_OPEN: begin
                seg_next = {SEG_P, SEG_A, SEG_S};  // reads PAS
            end
            MODE_LOCKED: begin
                seg_next = {3{SEG_DASH}};
            end
            default: begin
                seg_next = {3{SEG_BLANK}};
            end
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            seg <= {3{SEG_BLANK}};
        end else begin
            seg <= seg_next;
        end
    end

endmodule

//--- hw/alarm_tone.sv
`timescale 1ns/1ps

module alarm_tone #(
    parameter int TONE_HALF_PERIOD = 50000,
    parameter int ALARM_CYCLES     = 150000000
) (
    input  logic clk,
    input  logic arst_n,
    input  logic alarm,
    output logic buzzer
);

    localparam int DUR_W  = $clog2(ALARM_CYCLES + 1);
    localparam int HALF_W = $clog2(TONE_HALF_PERIOD + 1);

    logic              active;
    logic [DUR_W-1:0]  dur_cnt;   // cycles since the alarm pulse
    logic [HALF_W-1:0] half_cnt;  // cycles in the current half period

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            active   <= 1'b0;
            dur_cnt  <= '0;
            half_cnt <= '0;
            buzzer   <= 1'b0;
        end else if (alarm) begin
            active   <= 1'b1;  // also restarts a running tone
            dur_cnt  <= DUR_W'(1);
            half_cnt <= '0;
            buzzer   <= 1'b1;
        end else if (active) begin
            dur_cnt <= dur_cnt + 1'b1;
            if (dur_cnt == DUR_W'(ALARM_CYCLES - 1)) begin
                active <= 1'b0;  // tone over
                buzzer <= 1'b0;
            end else if (half_cnt == HALF_W'(TONE_HALF_PERIOD - 1)) begin
                half_cnt <= '0;
                buzzer   <= ~buzzer;
            end else begin
                half_cnt <= half_cnt + 1'b1;
            end
        end
    end

endmodule

//--- hw/keypad_lock_top.sv
`timescale 1ns/1ps

module keypad_lock_top import lock_pkg::*; #(
    parameter logic [11:0] PASSCODE         = 12'h246,
    parameter int          LOCKOUT_TRIES    = 6,
    parameter int          TRIES_W          = 4,
    parameter int          TONE_HALF_PERIOD = 50000,
    parameter int          ALARM_CYCLES     = 150000000
) (
    input  logic               clk,
    input  logic               arst_n,
    input  logic [15:0]        keys,
    output seg_row_t           seg,
    output logic [TRIES_W-1:0] tries,
    output logic               buzzer
);

    key_event_t key_event;
    lock_view_t view;
    logic       alarm;  // one pulse per wrong code

    key_decoder key_decoder_inst (
        .clk       (clk),
        .arst_n    (arst_n),
        .keys      (keys),
        .key_event (key_event)
    );

    code_lock #(
        .PASSCODE      (PASSCODE),
        .LOCKOUT_TRIES (LOCKOUT_TRIES),
        .TRIES_W       (TRIES_W)
    ) code_lock_inst (
        .clk       (clk),
        .arst_n    (arst_n),
        .key_event (key_event),
        .view      (view),
        .tries     (tries),
        .alarm     (alarm)
    );

    seg_display seg_display_inst (
        .clk    (clk),
        .arst_n (arst_n),
        .view   (view),
        .seg    (seg)
    );

    alarm_tone #(
        .TONE_HALF_PERIOD (TONE_HALF_PERIOD),
        .ALARM_CYCLES     (ALARM_CYCLES)
    ) alarm_tone_inst (
        .clk    (clk),
        .arst_n (arst_n),
        .alarm  (alarm),
        .buzzer (buzzer)
    );

endmodule

//--- tb/lock_tests.svh
task automatic enter_digit(input int d);
    press(digit_key(d));
    if (entered.size() < CODE_DIGITS) begin
        entered.push_back(d);  // extra digits are dropped
    end
    check_seg(entry_row(), $sformatf("after digit %0d", d));
endtask

task automatic random_code(output int a, output int b, output int c);
    do begin
        a = rand_digit();
        b = rand_digit();
        c = rand_digit();
    end while (a == 2 && b == 4 && c == 6);
endtask

task automatic enter_wrong_code();
    int a, b, c;
    random_code(a, b, c);
    enter_digit(a);
    enter_digit(b);
    enter_digit(c);
    press(ENTER_KEY);
    entered.delete();
    exp_tries++;
    check_tries("after wrong code");
    check_seg((exp_tries == MAX_TRIES) ? DASH_ROW : BLANK_ROW, "after wrong code");
endtask

// runs beside the enter press, from its drive edge
task automatic watch_tone();
    int k;
    k = 0;
    @(posedge clk);  // enter driven
    @(posedge clk);  // enter sampled
    @(negedge clk);
    while (!buzzer && k < 10) begin
        @(negedge clk);
        k++;
    end
    if (!buzzer) begin
        timeouts++;
        $display("buzzer did not start within 10 cycles after enter was sampled");
    end else begin
        checks++;
        assert (k == 3) else begin
            errors++;
            $display("Error at %0t ns: buzzer rose %0d cycles after enter, expected 3", $time, k);
        end
        // the alarm pulse comes two cycles after sampling
        for (int m = k - 2; m <= ALARM_LEN + 4; m++) begin
            check_buzzer(tone_level(m), m);
            @(negedge clk);
        end
    end
endtask

task automatic test_reset_entry();
    check_seg(BLANK_ROW, "after reset");
    check_tries("after reset");
    for (int i = 0; i <= CODE_DIGITS; i++) begin
        enter_digit(rand_digit());
    end
    press(CLR_ENTRY_KEY);
    entered.delete();
    check_seg(BLANK_ROW, "clear entry after four digits");
endtask

task automatic test_correct_code();
    seg_row_t open_row;
    open_row[2] = SEG_P;  // leftmost
    open_row[1] = SEG_A;
    open_row[0] = SEG_S;
    enter_digit(2);
    enter_digit(4);
    enter_digit(6);
    press(ENTER_KEY);
    check_seg(open_row, "after correct code");
    check_tries("after correct code");
    press(CLR_ENTRY_KEY);
    entered.delete();
    check_seg(BLANK_ROW, "clear entry while open");
    check_tries("clear entry while open");
endtask

task automatic test_wrong_code();
    int a, b, c;
    random_code(a, b, c);
    enter_digit(a);
    enter_digit(b);
    enter_digit(c);
    entered.delete();
    exp_tries++;
    fork
        press(ENTER_KEY);
        watch_tone();
    join
    check_seg(BLANK_ROW, "after wrong code");
    check_tries("after wrong code");
endtask

task automatic test_lockout();
    press(CLR_ALL_KEY);
    exp_tries = 0;
    check_tries("clear all before lockout");
    repeat (MAX_TRIES) enter_wrong_code();
    press(digit_key(2));
    press(digit_key(4));
    press(digit_key(6));
    press(ENTER_KEY);
    check_seg(DASH_ROW, "keys while locked");
    check_tries("keys while locked");
    press(CLR_ALL_KEY);
    exp_tries = 0;
    check_seg(BLANK_ROW, "clear all after lockout");
    check_tries("clear all after lockout");
endtask

task automatic test_key_rules();
    enter_wrong_code();  // tries above zero
    hold_key(digit_key(7), 20);
    entered.push_back(7);
    check_seg(entry_row(), "after a long hold");
    press(digit_key(1) | digit_key(2));
    check_seg(entry_row(), "two keys at once");
    press(16'h0002);
    press(16'h0004);
    press(16'h0010);
    check_seg(entry_row(), "unused keys");
    press(ENTER_KEY);
    check_seg(entry_row(), "enter with one digit");
    check_tries("enter with one digit");
    press(CLR_ENTRY_KEY);
    entered.delete();
    check_seg(BLANK_ROW, "clear entry during entry");
    check_tries("clear entry during entry");
endtask

//--- tb/lock_tb.sv
`timescale 1ns/1ps

module lock_tb import lock_pkg::*; ();

    localparam int MAX_TRIES = 3;
    localparam int TONE_HALF = 3;
    localparam int ALARM_LEN = 40;
    localparam int DIGIT_BIT [10] = '{3, 7, 6, 5, 11, 10, 9, 15, 14, 13};  // key bit of 0..9
    localparam logic [15:0] ENTER_KEY     = 16'h0001;
    localparam logic [15:0] CLR_ALL_KEY   = 16'h0100;
    localparam logic [15:0] CLR_ENTRY_KEY = 16'h1000;
    localparam seg_row_t BLANK_ROW = {3{SEG_BLANK}};
    localparam seg_row_t DASH_ROW  = {3{SEG_DASH}};

    logic        clk;
    logic        arst_n;
    logic [15:0] keys;
    seg_row_t    seg;
    logic [3:0]  tries;
    logic        buzzer;

    int unsigned lcg_state = 88;
    int          checks    = 0;
    int          errors    = 0;
    int          timeouts  = 0;
    int          entered[$];     // digits the lock should hold in entry order
    int          exp_tries = 0;

    keypad_lock_top #(
        .PASSCODE         (12'h246),
        .LOCKOUT_TRIES    (MAX_TRIES),
        .TRIES_W          (4),
        .TONE_HALF_PERIOD (TONE_HALF),
        .ALARM_CYCLES     (ALARM_LEN)
    ) keypad_lock_top_inst (
        .clk    (clk),
        .arst_n (arst_n),
        .keys   (keys),
        .seg    (seg),
        .tries  (tries),
        .buzzer (buzzer)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic int unsigned lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic int rand_digit();
        return int'((lcg_next() >> 16) % 10);
    endfunction

    function automatic logic [15:0] digit_key(input int d);
        return 16'd1 << DIGIT_BIT[d];
    endfunction

    // newest digit goes rightmost
    function automatic seg_row_t entry_row();
        seg_row_t row;
        row = BLANK_ROW;
        for (int i = 0; i < entered.size(); i++) begin
            row[i] = SEG_DIGIT[entered[entered.size() - 1 - i]];
        end
        return row;
    endfunction

    // buzzer level m cycles after the alarm pulse
    function automatic logic tone_level(input int m);
        return (m >= 1 && m < ALARM_LEN) ? (((m - 1) / TONE_HALF) % 2 == 0) : 1'b0;
    endfunction

    task automatic check_seg(input seg_row_t exp, input string what);
        checks++;
        assert (seg === exp) else begin
            errors++;
            $display("Error at %0t ns: %s, seg %h, expected %h", $time, what, seg, exp);
        end
    endtask

    task automatic check_tries(input string what);
        checks++;
        assert (tries === 4'(exp_tries)) else begin
            errors++;
            $display("Error at %0t ns: %s, tries %0d, expected %0d", $time, what, tries, exp_tries);
        end
    endtask

    task automatic check_buzzer(input logic exp, input int m);
        checks++;
        assert (buzzer === exp) else begin
            errors++;
            $display("Error at %0t ns: buzzer %b at %0d cycles after the alarm, expected %b",
                     $time, buzzer, m, exp);
        end
    endtask

    task automatic hold_key(input logic [15:0] k, input int cycles);
        @(posedge clk);
        keys <= k;
        repeat (cycles) @(posedge clk);
        keys <= '0;
        repeat (2) @(posedge clk);
        @(negedge clk);  // seg and tries settled
    endtask

    task automatic press(input logic [15:0] k);
        hold_key(k, 2);
    endtask

    `include "lock_tests.svh"

    initial begin
        arst_n = 1'b0;
        keys   = '0;
        repeat (10) @(posedge clk);
        arst_n <= 1'b1;
        @(negedge clk);
        test_reset_entry();
        test_wrong_code();
        test_correct_code();  // runs with one failed try on record
        test_lockout();
        test_key_rules();
        $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

//--- list.f
+incdir+tb
hw/lock_pkg.sv
hw/key_decoder.sv
hw/code_lock.sv
hw/seg_display.sv
hw/alarm_tone.sv
hw/keypad_lock_top.sv
tb/lock_tb.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f list.f --top-module lock_tb \
    && ./obj_dir/Vlock_tb | tee sim.log \
    && grep -q "All tests passed" sim.log \
    || exit 1
